// ==== flist.f ====
+incdir+verilog
verilog/video_pkg.sv
verilog/palette_ram.sv
verilog/tile_layer.sv
verilog/obj_layer.sv
verilog/col_pal.sv
verilog/video_top.sv
test/video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the video back end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module video_tb \
	-o video_sim || { echo "build failed"; exit 1; }
./obj_dir/video_sim > sim.log 2>&1
cat sim.log
grep -q -F -x "** PASS **" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
exit 0

// ==== test/video_tb.sv ====
// Video back end testbench
// Loads palettes, cell RAM and sprite list through the download port,
// then runs a pixel table twice around one palette rewrite
// Expected colors come from local copies of every downloaded memory
`timescale 1ns/1ps
`include "video_settings.svh"

module video_tb;

	localparam int N_TAB      = 16;
	// Download clocks, both palettes, cell RAM, sprite bytes, a few spare
	localparam int DL_CYCLES  = 2 * (1 << `PAL_AW) + (1 << `VRAM_AW) + 4 * `OBJ_NUM + 8;
	// Two table passes, one flush enable each, 4 clocks per enable
	localparam int RUN_CYCLES = 2 * (N_TAB + 1) * 4;
	localparam int WD_CYCLES  = 16 + DL_CYCLES + RUN_CYCLES + 100;

	// Sprite list, index 0 has top priority
	localparam logic [7:0] SPR_X [0:`OBJ_NUM-1] = '{8'd16, 8'd20, 8'd64, 8'd100};
	localparam logic [7:0] SPR_Y [0:`OBJ_NUM-1] = '{8'd16, 8'd20, 8'd40, 8'd120};
	// Sprite 2 has low bits 00 and lets the tile through
	localparam logic [5:0] SPR_CODE [0:`OBJ_NUM-1] = '{6'h2D, 6'h1E, 6'h24, 6'h3B};

	// Pixel table, {h_pos, v_pos, bank, cmp_blank_n}
	localparam logic [18:0] PIX_TAB [0:N_TAB-1] = '{
		{8'd3,   8'd5,   2'd0, 1'b1},  // tile only
		{8'd100, 8'd200, 2'd1, 1'b1},
		{8'd17,  8'd18,  2'd0, 1'b1},  // sprite 0
		{8'd21,  8'd22,  2'd2, 1'b1},  // overlap, sprite 0 wins
		{8'd26,  8'd26,  2'd3, 1'b1},  // sprite 1 alone
		{8'd66,  8'd44,  2'd0, 1'b1},  // clear sprite, tile shows
		{8'd103, 8'd125, 2'd1, 1'b1},  // sprite 3
		{8'd17,  8'd18,  2'd0, 1'b0},  // blanked inside a sprite
		{8'd200, 8'd10,  2'd2, 1'b0},
		{8'd3,   8'd5,   2'd1, 1'b1},  // same cell, other banks
		{8'd3,   8'd5,   2'd2, 1'b1},
		{8'd3,   8'd5,   2'd3, 1'b1},
		{8'd255, 8'd255, 2'd3, 1'b1},
		{8'd15,  8'd15,  2'd0, 1'b1},  // just outside sprite 0
		{8'd24,  8'd24,  2'd0, 1'b1},
		{8'd0,   8'd0,   2'd0, 1'b1}
	};

	logic        CLK_24M;
	logic        W_1EF_RST;
	logic        pix_en;
	logic [7:0]  h_pos;
	logic [7:0]  v_pos;
	logic        cmp_blank_n;
	logic [1:0]  bank;
	logic [15:0] dl_addr;
	logic        dl_wr;
	logic [7:0]  dl_data;
	logic [2:0]  r;
	logic [2:0]  g;
	logic [1:0]  b;

	// Model copies of the downloaded memories
	logic [`PAL_DW-1:0] pal_r_m [0:(1 << `PAL_AW) - 1];
	logic [`PAL_DW-1:0] pal_g_m [0:(1 << `PAL_AW) - 1];
	logic [`PIX_W-1:0]  vram_m  [0:(1 << `VRAM_AW) - 1];
	logic [31:0]        rng;

	video_top DUT (
		.CLK_24M     (CLK_24M),
		.W_1EF_RST   (W_1EF_RST),
		.pix_en      (pix_en),
		.h_pos       (h_pos),
		.v_pos       (v_pos),
		.cmp_blank_n (cmp_blank_n),
		.bank        (bank),
		.dl_addr     (dl_addr),
		.dl_wr       (dl_wr),
		.dl_data     (dl_data),
		.r           (r),
		.g           (g),
		.b           (b)
	);

	// ==============================
	// Clock and watchdog
	// ==============================
	initial
	begin
		CLK_24M = 1'b0;
		forever #2 CLK_24M = ~CLK_24M;
	end

	initial
	begin
		repeat (WD_CYCLES) @(posedge CLK_24M);
		$display("Timeout, the test did not finish within %0d clocks", WD_CYCLES);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// One download write, taken on the next rising edge
	task automatic dl_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge CLK_24M);
		#1;
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
	endtask

	task automatic dl_idle;
		@(posedge CLK_24M);
		#1;
		dl_wr = 1'b0;
	endtask

	// Reference color for one table entry, {r, g, b} before splitting
	function automatic logic [7:0] color_of(input logic [18:0] ent);
		int         hp;
		int         vp;
		int         i;
		logic       found;
		logic [5:0] obj;
		logic [5:0] mix;
		logic [7:0] pa;
		hp    = int'(ent[18:11]);
		vp    = int'(ent[10:3]);
		found = 1'b0;
		obj   = '0;
		// First box that holds the beam, lowest index first
		for (i = 0; i < `OBJ_NUM; i++)
		begin
			if (!found && hp >= int'(SPR_X[i]) && hp < int'(SPR_X[i]) + 8
				&& vp >= int'(SPR_Y[i]) && vp < int'(SPR_Y[i]) + 8)
			begin
				found = 1'b1;
				obj   = SPR_CODE[i];
			end
		end
		mix = (obj[1:0] != 2'b00) ? obj : vram_m[{ent[10:6], ent[18:14]}];
		// Blanking picks entry 0
		pa  = ent[0] ? {ent[2:1], mix} : 8'd0;
		return {~pal_r_m[pa], ~pal_g_m[pa]};
	endfunction

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic check_rgb(input logic [7:0] exp);
		check_val("r", {5'b0, r}, {5'b0, exp[7:5]});
		check_val("g", {5'b0, g}, {5'b0, exp[4:2]});
		check_val("b", {6'b0, b}, {6'b0, exp[1:0]});
	endtask

	// ==============================
	// Pixel run, one entry per enable
	// ==============================
	task automatic run_table;
		int k;
		for (k = 0; k <= N_TAB; k++)
		begin
			@(posedge CLK_24M);
			#1;
			pix_en = 1'b1;
			if (k < N_TAB)
				{h_pos, v_pos, bank, cmp_blank_n} = PIX_TAB[k];
			else
				cmp_blank_n = 1'b0;  // flush enable
			@(posedge CLK_24M);
			#1;
			pix_en = 1'b0;
			@(posedge CLK_24M);
			@(posedge CLK_24M);
			#1;
			// Previous entry was latched on this enable, RAM read one clock later
			if (k > 0)
				check_rgb(color_of(PIX_TAB[k-1]));
		end
	endtask

	initial
	begin
		logic [7:0] pa;
		W_1EF_RST   = 1'b0;
		pix_en      = 1'b0;
		h_pos       = '0;
		v_pos       = '0;
		cmp_blank_n = 1'b0;
		bank        = '0;
		dl_addr     = '0;
		dl_wr       = 1'b0;
		dl_data     = '0;
		rng         = 32'd43139;
		repeat (16) @(posedge CLK_24M);
		#1;
		W_1EF_RST = 1'b1;

		// Random palettes, upper data bits dropped by the RAM
		for (int i = 0; i < (1 << `PAL_AW); i++)
		begin
			rng = xorshift32(rng);
			dl_write({`DL_PAL_G_HI, 8'(i)}, rng[7:0]);
			pal_g_m[i] = rng[`PAL_DW-1:0];
			rng = xorshift32(rng);
			dl_write({`DL_PAL_R_HI, 8'(i)}, rng[7:0]);
			pal_r_m[i] = rng[`PAL_DW-1:0];
		end
		// Random cell RAM over pages F4 to F7
		for (int i = 0; i < (1 << `VRAM_AW); i++)
		begin
			rng = xorshift32(rng);
			dl_write(16'({`DL_VRAM_LO, 8'h00}) + 16'(i), rng[7:0]);
			vram_m[i] = rng[`PIX_W-1:0];
		end
		// Sprites, junk in the code top bits and reserved byte
		for (int n = 0; n < `OBJ_NUM; n++)
		begin
			dl_write({`DL_OBJ_HI, 8'(4 * n)}, SPR_X[n]);
			dl_write({`DL_OBJ_HI, 8'(4 * n + 1)}, SPR_Y[n]);
			dl_write({`DL_OBJ_HI, 8'(4 * n + 2)}, {2'b11, SPR_CODE[n]});
			dl_write({`DL_OBJ_HI, 8'(4 * n + 3)}, 8'hFF);
		end
		dl_idle();
		repeat (2) @(posedge CLK_24M);
		#1;
		// Latch still zero, entry 0 on the outputs
		check_rgb({~pal_r_m[0], ~pal_g_m[0]});

		run_table();

		// Flip the red word of the sprite 0 bank 0 entry
		pa = {2'b00, SPR_CODE[0]};
		dl_write({`DL_PAL_R_HI, pa}, {4'hA, ~pal_r_m[pa]});
		pal_r_m[pa] = ~pal_r_m[pa];
		dl_idle();

		run_table();

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== verilog/col_pal.sv ====
// Color palette block
// Tile/object priority mix, palette address latch with blank clear,
// two 256x4 palette RAMs and inverted 3-3-2 RGB out
`timescale 1ns/1ps
`include "video_settings.svh"

module col_pal (
	input  logic              CLK_24M,
	input  logic              W_1EF_RST,
	input  logic              pix_en,
	input  logic [`PIX_W-1:0] tile_pix,
	input  logic [`PIX_W-1:0] obj_pix,
	input  logic              cmp_blank_n,
	input  logic [1:0]        bank,
	input  logic [15:0]       dl_addr,
	input  logic              dl_wr,
	input  logic [7:0]        dl_data,
	output logic [2:0]        r,
	output logic [2:0]        g,
	output logic [1:0]        b
);

	import video_pkg::*;

	logic              blank_s1_n;
	logic [1:0]        bank_s1;
	logic [`PIX_W-1:0] mix_pix;
	logic [9:0]        pal_lat_d;
	logic [9:0]        pal_lat;
	logic [`PAL_DW-1:0] red_q;
	logic [`PAL_DW-1:0] grn_q;
	logic              red_we;
	logic              grn_we;

	// ==============================
	// Stage 1 alignment
	// ==============================
	// Blank and bank held one enable, in step with the layer registers
	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
		begin
			blank_s1_n <= 1'b0;
			bank_s1    <= 2'b00;
		end
		else if (pix_en)
		begin
			blank_s1_n <= cmp_blank_n;
			bank_s1    <= bank;
		end
	end

	// Object wins unless its low color bits are zero
	assign mix_pix = (obj_pix[1:0] != 2'b00) ? obj_pix : tile_pix;

	// Bank, pixel, opaque flag, blank flag
	assign pal_lat_d = {bank_s1, mix_pix, |mix_pix[1:0], blank_s1_n};

	// ==============================
	// Stage 2 latch
	// ==============================
	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
			pal_lat <= '0;
		else if (pix_en)
			// Blanked sample forces palette entry 0
			pal_lat <= blank_s1_n ? pal_lat_d : '0;
	end

	// Download strobes per palette
	assign grn_we = dl_wr && (region_of(dl_addr) == REG_PAL_G);
	assign red_we = dl_wr && (region_of(dl_addr) == REG_PAL_R);

	// Green/blue word
	palette_ram #(.aw(`PAL_AW), .dw(`PAL_DW)) pal_g (
		.clock_a   (CLK_24M),
		.address_a (pal_lat[9:2]),
		.q_a       (grn_q),
		.clock_b   (CLK_24M),
		.address_b (dl_addr[`PAL_AW-1:0]),
		.wren_b    (grn_we),
		.data_b    (dl_data[`PAL_DW-1:0])
	);

	// Red word
	palette_ram #(.aw(`PAL_AW), .dw(`PAL_DW)) pal_r (
		.clock_a   (CLK_24M),
		.address_a (pal_lat[9:2]),
		.q_a       (red_q),
		.clock_b   (CLK_24M),
		.address_b (dl_addr[`PAL_AW-1:0]),
		.wren_b    (red_we),
		.data_b    (dl_data[`PAL_DW-1:0])
	);

	// Palette data is stored active low
	assign {r, g, b} = {~red_q, ~grn_q};

	// A blanked stage-1 sample empties the latch on the next enable
	a_blank_clear: assert property (@(posedge CLK_24M) disable iff (!W_1EF_RST)
		(pix_en && !blank_s1_n) |=> (pal_lat == '0));

endmodule

// ==== verilog/obj_layer.sv ====
// Object layer
// Four-entry sprite list, each sprite fills an 8x8 box with one pixel code
// Lowest list index wins where boxes overlap
`timescale 1ns/1ps
`include "video_settings.svh"

module obj_layer (
	input  logic              CLK_24M,
	input  logic              W_1EF_RST,
	input  logic              pix_en,
	input  logic [7:0]        h_pos,
	input  logic [7:0]        v_pos,
	input  logic [15:0]       dl_addr,
	input  logic              dl_wr,
	input  logic [7:0]        dl_data,
	output logic [`PIX_W-1:0] obj_pix
);

	import video_pkg::*;

	localparam int OBJ_IW = $clog2(`OBJ_NUM);

	// Sprite list, split by byte lane
	logic [7:0]          obj_x    [0:`OBJ_NUM-1];
	logic [7:0]          obj_y    [0:`OBJ_NUM-1];
	logic [`PIX_W-1:0]   obj_code [0:`OBJ_NUM-1];
	logic                obj_we;
	logic [OBJ_IW-1:0]   obj_idx;
	logic [`OBJ_NUM-1:0] hit;
	logic [`PIX_W-1:0]   hit_code;

	// ==============================
	// Download write
	// ==============================
	assign obj_we  = dl_wr && (region_of(dl_addr) == REG_OBJ);
	// Byte 4n+k goes to sprite n, lane k
	assign obj_idx = dl_addr[OBJ_IW+1:2];

	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
		begin
			// Cleared list covers (0,0) with code 0, so nothing shows
			for (int i = 0; i < `OBJ_NUM; i++)
			begin
				obj_x[i]    <= '0;
				obj_y[i]    <= '0;
				obj_code[i] <= '0;
			end
		end
		else if (obj_we)
		begin
			case (dl_addr[1:0])
				2'd0: obj_x[obj_idx] <= dl_data;
				2'd1: obj_y[obj_idx] <= dl_data;
				2'd2: obj_code[obj_idx] <= dl_data[`PIX_W-1:0];
				default: ;  // reserved byte is dropped
			endcase
		end
	end

	// ==============================
	// Box compare, all sprites at once
	// ==============================
	for (genvar i = 0; i < `OBJ_NUM; i++)
	begin : g_hit
		logic [8:0] dx;
		logic [8:0] dy;
		// Nine-bit difference, negative offsets show up in bit 8
		assign dx     = {1'b0, h_pos} - {1'b0, obj_x[i]};
		assign dy     = {1'b0, v_pos} - {1'b0, obj_y[i]};
		assign hit[i] = (dx[8:3] == 6'd0) && (dy[8:3] == 6'd0);
	end

	// Priority pick, scanned from the top so index 0 is assigned last
	always_comb
	begin
		hit_code = '0;
		for (int i = `OBJ_NUM - 1; i >= 0; i--)
		begin
			if (hit[i])
				hit_code = obj_code[i];
		end
	end

	// Stage 1 register
	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
			obj_pix <= '0;
		else if (pix_en)
			obj_pix <= hit_code;
	end

	// Object pixel stays defined once out of reset
	a_obj_known: assert property (@(posedge CLK_24M) disable iff (!W_1EF_RST)
		!$isunknown(obj_pix));

endmodule

// ==== verilog/palette_ram.sv ====
// Two-port palette RAM
// Registered read on port a for the pixel path, write on port b for download
`timescale 1ns/1ps
`include "video_settings.svh"

module palette_ram #(
	parameter int aw = `PAL_AW,
	parameter int dw = `PAL_DW
) (
	input  logic          clock_a,
	input  logic [aw-1:0] address_a,
	output logic [dw-1:0] q_a,
	input  logic          clock_b,
	input  logic [aw-1:0] address_b,
	input  logic          wren_b,
	input  logic [dw-1:0] data_b
);

	// Storage array
	logic [dw-1:0] mem [0:(1 << aw) - 1];

	// Pixel side, one clock read latency
	always_ff @(posedge clock_a)
	begin
		q_a <= mem[address_a];
	end

	// Download side
	always_ff @(posedge clock_b)
	begin
		if (wren_b)
			mem[address_b] <= data_b;
	end

	// A write must land on a known word
	a_wr_addr_known: assert property (@(posedge clock_b) wren_b |-> !$isunknown(address_b));

endmodule

// ==== verilog/tile_layer.sv ====
// Background tile layer
// 32x32 cell video RAM, one 6-bit pixel code per cell, read on the pixel enable
`timescale 1ns/1ps
`include "video_settings.svh"

module tile_layer (
	input  logic              CLK_24M,
	input  logic              W_1EF_RST,
	input  logic              pix_en,
	input  logic [7:0]        h_pos,
	input  logic [7:0]        v_pos,
	input  logic [15:0]       dl_addr,
	input  logic              dl_wr,
	input  logic [7:0]        dl_data,
	output logic [`PIX_W-1:0] tile_pix
);

	import video_pkg::*;

	// Cell storage
	logic [`PIX_W-1:0]   vram [0:(1 << `VRAM_AW) - 1];
	logic                vram_we;
	logic [`VRAM_AW-1:0] cell_addr;

	// ==============================
	// Download write
	// ==============================
	assign vram_we = dl_wr && (region_of(dl_addr) == REG_VRAM);

	always_ff @(posedge CLK_24M)
	begin
		// Only the pixel code bits are kept
		if (vram_we)
			vram[dl_addr[`VRAM_AW-1:0]] <= dl_data[`PIX_W-1:0];
	end

	// ==============================
	// Pixel read
	// ==============================
	// Cell row from v_pos, cell column from h_pos, 8x8 pixels per cell
	assign cell_addr = {v_pos[7:3], h_pos[7:3]};

	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
			tile_pix <= '0;
		else if (pix_en)
			tile_pix <= vram[cell_addr];
	end

endmodule

// ==== verilog/video_pkg.sv ====
// Video back end types
// Download region enum and the address decode shared by all memory owners
`include "video_settings.svh"

package video_pkg;

	// Memory regions reachable through the download port
	typedef enum logic [2:0] {
		REG_NONE,
		REG_PAL_G,
		REG_PAL_R,
		REG_VRAM,
		REG_OBJ
	} dl_region_t;

	// Region decode from the 16-bit download address
	function automatic dl_region_t region_of(input logic [15:0] addr);
		dl_region_t sel;
		sel = REG_NONE;
		if (addr[15:8] == `DL_PAL_G_HI)
			sel = REG_PAL_G;
		else if (addr[15:8] == `DL_PAL_R_HI)
			sel = REG_PAL_R;
		else if ((addr[15:8] >= `DL_VRAM_LO) && (addr[15:8] <= `DL_VRAM_TOP))
			sel = REG_VRAM;
		// Only the low 4*OBJ_NUM bytes of page F8 hold sprites
		else if ((addr[15:8] == `DL_OBJ_HI) && (addr[7:0] < (4 * `OBJ_NUM)))
			sel = REG_OBJ;
		return sel;
	endfunction

endpackage

// ==== verilog/video_settings.svh ====
// Video back end sizes
// RAM widths, sprite count and the download address map
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// ==============================
// Memory sizes
// ==============================

// Palette RAM, 256 words of 4 bits
`define PAL_AW 8
`define PAL_DW 4
// Background cell RAM, 32x32 cells
`define VRAM_AW 10
// Entries in the sprite list
`define OBJ_NUM 4
// Pixel code width out of both layers
`define PIX_W 6

// ==============================
// Download map, upper address byte
// ==============================
`define DL_PAL_G_HI 8'hF0
`define DL_PAL_R_HI 8'hF1
`define DL_VRAM_LO 8'hF4
`define DL_VRAM_TOP 8'hF7
`define DL_OBJ_HI 8'hF8

`endif

// ==== verilog/video_top.sv ====
// Video pixel back end
// Background tile layer and object layer feeding the color palette block
// Beam timing and blanking come from outside, RAMs load through one download port
`timescale 1ns/1ps
`include "video_settings.svh"

module video_top (
	input  logic        CLK_24M,
	input  logic        W_1EF_RST,
	input  logic        pix_en,
	input  logic [7:0]  h_pos,
	input  logic [7:0]  v_pos,
	input  logic        cmp_blank_n,
	input  logic [1:0]  bank,
	input  logic [15:0] dl_addr,
	input  logic        dl_wr,
	input  logic [7:0]  dl_data,
	output logic [2:0]  r,
	output logic [2:0]  g,
	output logic [1:0]  b
);

	// Stage 1 pixel codes
	logic [`PIX_W-1:0] tile_pix;
	logic [`PIX_W-1:0] obj_pix;

	// ==============================
	// Pixel sources
	// ==============================
	tile_layer u_tile (
		.CLK_24M   (CLK_24M),
		.W_1EF_RST (W_1EF_RST),
		.pix_en    (pix_en),
		.h_pos     (h_pos),
		.v_pos     (v_pos),
		.dl_addr   (dl_addr),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.tile_pix  (tile_pix)
	);

	obj_layer u_obj (
		.CLK_24M   (CLK_24M),
		.W_1EF_RST (W_1EF_RST),
		.pix_en    (pix_en),
		.h_pos     (h_pos),
		.v_pos     (v_pos),
		.dl_addr   (dl_addr),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.obj_pix   (obj_pix)
	);

	// Mix and color lookup
	col_pal u_col_pal (
		.CLK_24M     (CLK_24M),
		.W_1EF_RST   (W_1EF_RST),
		.pix_en      (pix_en),
		.tile_pix    (tile_pix),
		.obj_pix     (obj_pix),
		.cmp_blank_n (cmp_blank_n),
		.bank        (bank),
		.dl_addr     (dl_addr),
		.dl_wr       (dl_wr),
		.dl_data     (dl_data),
		.r           (r),
		.g           (g),
		.b           (b)
	);

endmodule
